// ==== all.f ====
+incdir+source
source/conv_pkg.sv
source/reset_sequencer.sv
source/conv_sequencer.sv
source/row_window.sv
source/conv_row_engine.sv
source/conv_top.sv
testbench/mem_model.sv
testbench/conv_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and pass only if the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --timescale 1ns/100ps \
  --top-module conv_tb -f all.f -o conv_sim &&
./obj_dir/conv_sim | tee /dev/stderr | grep -qF '** PASS **' &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }

// ==== testbench/conv_tb.sv ====
`include "conv_config.svh"

module conv_tb import conv_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  logic      clk_40M;
  logic      clk_40MHz_locked;
  logic      start;
  logic      busy;
  logic      done;
  logic      mem_en;
  logic      mem_wr;
  mem_addr_t mem_adr;
  mem_word_t mem_wdata;
  logic      mem_ready;
  logic      mem_rvalid;
  mem_word_t mem_rdata;
  logic      load_en;
  mem_addr_t load_adr;
  mem_word_t load_data;

  int        seed = 32'h47ea_d6c4;
  bit        watch_idle;           // idle outputs checked from here on
  int        runs_started = 0;
  int        runs_done = 0;        // owned by the checker
  int        rd_seen = 0;          // reads this run, weight read included
  int        wr_seen = 0;
  mem_word_t img_w;                // current run image
  mem_word_t img_rows [`CONV_MAP_ROWS];

  conv_top UUT (.*);

  mem_model u_mem (.*);

  initial begin
    clk_40M = 1'b0;
    forever #5 clk_40M = ~clk_40M;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // 3x3 over rows r..r+2, shift, clamp to int8, bytes 62 and 63 zero
  function automatic mem_word_t ref_row(mem_word_t w, mem_word_t top, mem_word_t mid,
                                        mem_word_t bot);
    mem_word_t rows [3];
    mem_word_t res;
    pixel_t    px;
    pixel_t    wt;
    shift_t    sh;
    int        sum;
    res     = '0;
    rows[0] = top;
    rows[1] = mid;
    rows[2] = bot;
    sh      = w[72 +: 4];  // byte 9 low nibble
    for (int c = 0; c < `CONV_OUT_LANES; c++) begin
      sum = 0;
      for (int i = 0; i < 3; i++) begin
        for (int j = 0; j < 3; j++) begin
          px  = pixel_t'(rows[i][8*(c+j) +: 8]);
          wt  = pixel_t'(w[8*(3*i+j) +: 8]);
          sum += int'(px) * int'(wt);
        end
      end
      sum = sum >>> sh;
      if (sum > 127) sum = 127;
      else if (sum < -128) sum = -128;
      res[8*c +: 8] = 8'(sum);
    end
    return res;
  endfunction

  function automatic mem_word_t random_word();
    mem_word_t word;
    for (int q = 0; q < `CONV_LANES / 4; q++) word[32*q +: 32] = $random(seed);
    return word;
  endfunction

  task automatic stop_fail(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input mem_word_t got, input mem_word_t exp);
    if (got !== exp) stop_fail($sformatf("** Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
    if (got !== exp) stop_fail($sformatf("** Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) stop_fail($sformatf("** Error: %s got %h expected %h", name, got, exp));
  endtask

  // one request taken by memory on the coming edge
  task automatic log_request();
    int r;
    check_flag("busy", busy, 1'b1);
    if (!mem_wr) begin
      if (rd_seen == 0) check_addr("mem_adr", mem_adr, mem_addr_t'(`CONV_WEIGHT_ADDR));
      else if (rd_seen > `CONV_MAP_ROWS) stop_fail("row read past the last input row");
      else check_addr("mem_adr", mem_adr, mem_addr_t'(`CONV_IN_BASE + rd_seen - 1));
      rd_seen++;
    end else begin
      r = wr_seen;
      if (r >= `CONV_OUT_ROWS) stop_fail("more result writes than output rows in one run");
      if (rd_seen < r + 4) begin  // weight read plus rows 0..r+2
        stop_fail($sformatf("output row %0d written before input row %0d was read", r, r + 2));
      end
      check_addr("mem_adr", mem_adr, mem_addr_t'(`CONV_OUT_BASE + r));
      check_word($sformatf("mem_wdata row %0d", r), mem_wdata,
                 ref_row(img_w, img_rows[r], img_rows[r+1], img_rows[r+2]));
      wr_seen++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checker, samples on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_40M) begin
    if (runs_started == runs_done) begin
      if (watch_idle) begin  // no run, nothing may move
        check_flag("mem_en", mem_en, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
      end
    end else begin
      if (mem_en && mem_ready) log_request();
      if (done) begin
        check_flag("busy", busy, 1'b0);
        if (wr_seen != `CONV_OUT_ROWS) begin
          stop_fail($sformatf("done after %0d result writes", wr_seen));
        end
        rd_seen = 0;
        wr_seen = 0;
        runs_done++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic preload(input mem_addr_t adr, input mem_word_t word);
    load_en   = 1'b1;
    load_adr  = adr;
    load_data = word;
    @(posedge clk_40M);
    #1 load_en = 1'b0;
  endtask

  // saturating image uses pixels of 127, -127, -128 and all taps -128
  task automatic run_conv(input bit saturate);
    int runs_before;
    runs_before = runs_started;
    img_w = saturate ? mem_word_t'({9{8'h80}}) : random_word();  // shift 0 when saturating
    for (int k = 0; k < `CONV_MAP_ROWS; k++) begin
      img_rows[k] = random_word();
      for (int b = 0; saturate && b < `CONV_LANES; b++) begin
        case ({$random(seed)} % 3)
          0: img_rows[k][8*b +: 8] = 8'h7f;
          1: img_rows[k][8*b +: 8] = 8'h81;
          default: img_rows[k][8*b +: 8] = 8'h80;
        endcase
      end
      preload(mem_addr_t'(`CONV_IN_BASE + k), img_rows[k]);
    end
    preload(mem_addr_t'(`CONV_WEIGHT_ADDR), img_w);
    runs_started++;
    start = 1'b1;
    @(posedge clk_40M);
    #1 start = 1'b0;
    wait (runs_done == runs_before + 1);
    repeat (3) @(posedge clk_40M);  // a few idle cycles checked
    #1;
  endtask

  initial begin
    clk_40MHz_locked = 1'b0;
    start            = 1'b0;
    load_en          = 1'b0;
    load_adr         = '0;
    load_data        = '0;
    watch_idle       = 1'b0;
    repeat (2) @(posedge clk_40M);
    #1 watch_idle = 1'b1;
    repeat (2) @(posedge clk_40M);
    #1 start = 1'b1;  // clock not locked yet
    @(posedge clk_40M);
    #1 start = 1'b0;
    repeat (11) @(posedge clk_40M);
    #1 clk_40MHz_locked = 1'b1;  // after 16 cycles
    repeat (100) @(posedge clk_40M);
    #1 start = 1'b1;  // rst_n still low
    @(posedge clk_40M);
    #1 start = 1'b0;
    repeat (`CONV_RST_CNT) @(posedge clk_40M);
    #1;
    run_conv(1'b0);
    run_conv(1'b1);
    run_conv(1'b0);
    $display("** PASS **");
    $finish;
  end

  // watchdog, reset time plus a budget per run
  initial begin
    repeat (`CONV_RST_CNT + 16 + 3 * (`CONV_MAP_ROWS * 20 + 200)) @(posedge clk_40M);
    stop_fail("timeout, the three runs did not finish in time");
  end

endmodule

// ==== testbench/mem_model.sv ====
module mem_model import conv_pkg::*; (
  input  logic      clk_40M,
  // request port of the DUT
  input  logic      mem_en,
  input  logic      mem_wr,
  input  mem_addr_t mem_adr,
  input  mem_word_t mem_wdata,
  output logic      mem_ready,
  output logic      mem_rvalid,
  output mem_word_t mem_rdata,
  // preload from the testbench
  input  logic      load_en,
  input  mem_addr_t load_adr,
  input  mem_word_t load_data
);

  timeunit 1ns;
  timeprecision 100ps;

  mem_word_t mem [128];
  mem_word_t rsp_data [$];  // read data in request order
  int        rsp_due [$];   // cycle in which each response is driven
  int        cyc;
  int        last_due;      // keeps responses in order, one per cycle
  int        due;
  int        seed;

  initial begin
    seed       = 32'h47ea_d6c4;
    cyc        = 0;
    last_due   = 0;
    mem_ready  = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    for (int a = 0; a < 128; a++) mem[a] = {16{32'hdead_0000 | 32'(a)}};  // per-address fill
  end

  always @(posedge clk_40M) begin
    cyc++;
    if (load_en) mem[load_adr[6:0]] = load_data;
    if (mem_en && mem_ready) begin
      if (mem_wr) begin
        mem[mem_adr[6:0]] = mem_wdata;
      end else begin
        due = cyc + 1 + int'({$random(seed)} % 32'd6);  // latency 1..6
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        rsp_data.push_back(mem[mem_adr[6:0]]);
        rsp_due.push_back(due);
      end
    end
    #1;
    mem_ready  = 1'($random(seed));  // random back-pressure
    mem_rvalid = 1'b0;
    if (rsp_due.size() > 0 && rsp_due[0] == cyc) begin
      mem_rvalid = 1'b1;
      mem_rdata  = rsp_data.pop_front();
      void'(rsp_due.pop_front());
    end
  end

endmodule

// ==== source/conv_top.sv ====
module conv_top import conv_pkg::*; (
  input  logic      clk_40M,
  input  logic      clk_40MHz_locked,  // async active-low reset source
  input  logic      start,
  output logic      busy,
  output logic      done,
  // memory request
  output logic      mem_en,
  output logic      mem_wr,
  output mem_addr_t mem_adr,
  output mem_word_t mem_wdata,
  input  logic      mem_ready,
  // memory response
  input  logic      mem_rvalid,
  input  mem_word_t mem_rdata
);

  logic      rst_n;      // internal reset, counted after lock
  mem_word_t weights;
  logic      row_valid;
  logic      row_first;
  mem_word_t row_data;
  logic      win_valid;
  logic      win_ready;
  mem_word_t win_top;
  mem_word_t win_mid;
  mem_word_t win_bot;
  logic      out_valid;
  logic      out_ready;
  mem_word_t out_data;

  ////////////////////////////////////////////////////////////////////////////
  // reset and memory-facing control
  ////////////////////////////////////////////////////////////////////////////

  reset_sequencer u_reset_sequencer (
    .clk_40M          (clk_40M),
    .clk_40MHz_locked (clk_40MHz_locked),
    .rst_n            (rst_n)
  );

  conv_sequencer u_conv_sequencer (
    .clk_40M    (clk_40M),
    .rst_n      (rst_n),
    .start      (start),
    .busy       (busy),
    .done       (done),
    .mem_en     (mem_en),
    .mem_wr     (mem_wr),
    .mem_adr    (mem_adr),
    .mem_wdata  (mem_wdata),
    .mem_ready  (mem_ready),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata),
    .weights    (weights),
    .row_valid  (row_valid),
    .row_first  (row_first),
    .row_data   (row_data),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ready  (out_ready)
  );

  // datapath, rows in, packed result rows out
  row_window u_row_window (
    .clk_40M   (clk_40M),
    .rst_n     (rst_n),
    .row_valid (row_valid),
    .row_first (row_first),
    .row_data  (row_data),
    .win_valid (win_valid),
    .win_top   (win_top),
    .win_mid   (win_mid),
    .win_bot   (win_bot),
    .win_ready (win_ready)
  );

  conv_row_engine u_conv_row_engine (
    .clk_40M   (clk_40M),
    .rst_n     (rst_n),
    .weights   (weights),
    .win_valid (win_valid),
    .win_ready (win_ready),
    .win_top   (win_top),
    .win_mid   (win_mid),
    .win_bot   (win_bot),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

endmodule

// ==== source/conv_row_engine.sv ====
`include "conv_config.svh"

module conv_row_engine import conv_pkg::*; (
  input  logic      clk_40M,
  input  logic      rst_n,
  input  mem_word_t weights,    // taps in bytes 0..8, shift in byte 9
  input  logic      win_valid,
  output logic      win_ready,
  input  mem_word_t win_top,
  input  mem_word_t win_mid,
  input  mem_word_t win_bot,
  output logic      out_valid,
  output mem_word_t out_data,
  input  logic      out_ready
);

  localparam int KS    = `CONV_KSIZE;
  localparam int LANES = `CONV_OUT_LANES;

  pixel_t    tap [KS*KS];       // row-major kernel
  shift_t    shift_amt;
  mem_word_t win_rows [KS];     // 0 is top
  acc_t      mac_sum [LANES];   // stage 1 input
  acc_t      s1_acc [LANES];
  logic      s1_valid;
  mem_word_t quant_word;        // stage 2 input
  logic      s1_adv;
  logic      s2_adv;

  // clamp to int8
  function automatic pixel_t sat8(acc_t v);
    if (v > acc_t'(127)) return pixel_t'(127);
    else if (v < acc_t'(-128)) return pixel_t'(-128);
    else return pixel_t'(v[7:0]);
  endfunction

  always_comb begin
    for (int k = 0; k < KS*KS; k++) tap[k] = pixel_t'(weights[8*k +: 8]);
  end
  assign shift_amt = weights[8*`CONV_SHIFT_BYTE +: 4];

  assign win_rows[0] = win_top;
  assign win_rows[1] = win_mid;
  assign win_rows[2] = win_bot;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1, 3x3 multiply-accumulate per lane
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < LANES; c++) begin
      mac_sum[c] = '0;
      for (int i = 0; i < KS; i++) begin
        for (int j = 0; j < KS; j++) begin
          // sign extend first, the product fits in acc_t
          mac_sum[c] = mac_sum[c]
                     + acc_t'(pixel_t'(win_rows[i][8*(c+j) +: 8])) * acc_t'(tap[KS*i+j]);
        end
      end
    end
  end

  // stage 2, requantize and pack, top two bytes stay zero
  always_comb begin
    quant_word = '0;
    for (int c = 0; c < LANES; c++) quant_word[8*c +: 8] = sat8(s1_acc[c] >>> shift_amt);
  end

  ////////////////////////////////////////////////////////////////////////////
  // pipeline control
  ////////////////////////////////////////////////////////////////////////////

  assign s2_adv    = !out_valid || out_ready;  // output free or leaving
  assign s1_adv    = !s1_valid || s2_adv;
  assign win_ready = s1_adv;

  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (s1_adv) s1_valid <= win_valid;
      if (s2_adv) out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk_40M) begin
    if (s1_adv && win_valid) s1_acc <= mac_sum;
    if (s2_adv && s1_valid) out_data <= quant_word;
  end

endmodule

// ==== source/row_window.sv ====
module row_window import conv_pkg::*; (
  input  logic      clk_40M,
  input  logic      rst_n,
  input  logic      row_valid,
  input  logic      row_first,  // first row of a run, restarts the fill
  input  mem_word_t row_data,
  output logic      win_valid,
  output mem_word_t win_top,    // oldest row, r
  output mem_word_t win_mid,    // r+1
  output mem_word_t win_bot,    // newest row, r+2
  input  logic      win_ready
);

  logic [1:0] fill;       // rows held, saturates at 3
  logic [1:0] fill_next;

  always_comb begin
    if (row_first) fill_next = 2'd1;
    else if (fill == 2'd3) fill_next = 2'd3;
    else fill_next = fill + 2'd1;
  end

  // row shift register
  always_ff @(posedge clk_40M) begin
    if (row_valid) begin
      win_top <= win_mid;
      win_mid <= win_bot;
      win_bot <= row_data;
    end
  end

  // a new row may coincide with the accept of the previous window
  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      fill      <= '0;
      win_valid <= 1'b0;
    end else if (row_valid) begin
      fill      <= fill_next;
      win_valid <= (fill_next == 2'd3);  // third row or later
    end else if (win_ready) begin
      win_valid <= 1'b0;  // consumed
    end
  end

endmodule

// ==== source/conv_sequencer.sv ====
`include "conv_config.svh"

module conv_sequencer import conv_pkg::*; (
  input  logic      clk_40M,
  input  logic      rst_n,
  input  logic      start,
  output logic      busy,
  output logic      done,
  // memory request, mem_en is valid, mem_ready is ready
  output logic      mem_en,
  output logic      mem_wr,
  output mem_addr_t mem_adr,
  output mem_word_t mem_wdata,
  input  logic      mem_ready,
  // memory response, in request order
  input  logic      mem_rvalid,
  input  mem_word_t mem_rdata,
  // to the engine, stable for the run
  output mem_word_t weights,
  // to the row window
  output logic      row_valid,
  output logic      row_first,
  output mem_word_t row_data,
  // results from the engine
  input  logic      out_valid,
  input  mem_word_t out_data,
  output logic      out_ready
);

  localparam row_cnt_t  MAP_ROWS    = row_cnt_t'(`CONV_MAP_ROWS);
  localparam row_cnt_t  OUT_ROWS    = row_cnt_t'(`CONV_OUT_ROWS);
  localparam row_cnt_t  RD_AHEAD    = row_cnt_t'(2 + `CONV_MAX_INFLIGHT);
  localparam mem_addr_t WEIGHT_ADDR = mem_addr_t'(`CONV_WEIGHT_ADDR);
  localparam mem_addr_t IN_BASE     = mem_addr_t'(`CONV_IN_BASE);
  localparam mem_addr_t OUT_BASE    = mem_addr_t'(`CONV_OUT_BASE);

  seq_state_t state;
  row_cnt_t   rd_cnt;   // row reads loaded into the request slot
  row_cnt_t   rsp_cnt;  // responses this run, 0 is the weight word
  row_cnt_t   wr_cnt;   // result writes loaded into the request slot

  logic req_accept;  // request slot handed to memory this edge
  logic rd_ok;       // read credit available
  logic wr_take;     // engine result moves into the slot
  logic rd_load;     // next row read moves into the slot
  logic last_wr;     // 14th write accepted

  ////////////////////////////////////////////////////////////////////////////
  // slot and credit decode
  ////////////////////////////////////////////////////////////////////////////

  assign req_accept = mem_en & mem_ready;

  // rows 0 and 1 always pass, later rows are limited by written outputs
  assign rd_ok = (rd_cnt < MAP_ROWS) && (rd_cnt < wr_cnt + RD_AHEAD);

  assign out_ready = (state == STREAM) && !mem_en;  // slot empty
  assign wr_take   = out_valid & out_ready;
  assign rd_load   = (state == STREAM) && !mem_en && !out_valid && rd_ok;  // writes first
  assign last_wr   = req_accept & mem_wr & (wr_cnt == OUT_ROWS);

  assign busy = (state != IDLE) && (state != FINISH);
  assign done = (state == FINISH);  // one cycle, busy already low

  // responses after the weight word are rows, in order
  assign row_valid = mem_rvalid & (rsp_cnt != '0);
  assign row_first = mem_rvalid & (rsp_cnt == row_cnt_t'(1));
  assign row_data  = mem_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // FSM and counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      mem_en  <= 1'b0;
      mem_wr  <= 1'b0;
      rd_cnt  <= '0;
      rsp_cnt <= '0;
      wr_cnt  <= '0;
    end else begin
      if (req_accept) mem_en <= 1'b0;  // slot frees after handover
      if (mem_rvalid) rsp_cnt <= rsp_cnt + row_cnt_t'(1);
      case (state)
        IDLE: begin
          if (start) begin
            rd_cnt  <= '0;
            rsp_cnt <= '0;
            wr_cnt  <= '0;
            state   <= LOAD_WEIGHTS;
          end
        end
        LOAD_WEIGHTS: begin  // slot is always empty here
          mem_en <= 1'b1;
          mem_wr <= 1'b0;
          state  <= WAIT_WEIGHTS;
        end
        WAIT_WEIGHTS: begin
          if (mem_rvalid) state <= STREAM;  // only read outstanding
        end
        STREAM: begin
          if (last_wr) state <= FINISH;
          if (wr_take) begin
            mem_en <= 1'b1;
            mem_wr <= 1'b1;
            wr_cnt <= wr_cnt + row_cnt_t'(1);
          end else if (rd_load) begin
            mem_en <= 1'b1;
            mem_wr <= 1'b0;
            rd_cnt <= rd_cnt + row_cnt_t'(1);
          end
        end
        FINISH: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // request payload and weight capture
  always_ff @(posedge clk_40M) begin
    if (state == LOAD_WEIGHTS) begin
      mem_adr <= WEIGHT_ADDR;
    end else if (wr_take) begin
      mem_adr   <= OUT_BASE + mem_addr_t'(wr_cnt);  // output row = write count
      mem_wdata <= out_data;
    end else if (rd_load) begin
      mem_adr <= IN_BASE + mem_addr_t'(rd_cnt);
    end
    if (mem_rvalid && (rsp_cnt == '0)) weights <= mem_rdata;  // first response
  end

endmodule

// ==== source/reset_sequencer.sv ====
`include "conv_config.svh"

module reset_sequencer (
  input  logic clk_40M,
  input  logic clk_40MHz_locked,  // async, low while the clock is not locked
  output logic rst_n
);

  localparam logic [15:0] RST_CNT = 16'(`CONV_RST_CNT);

  logic [15:0] rst_cnt;  // cycles since lock, saturates at RST_CNT

  ////////////////////////////////////////////////////////////////////////////
  // counted power-on release
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_40M or negedge clk_40MHz_locked) begin
    if (!clk_40MHz_locked) begin
      rst_cnt <= '0;
    end else if (rst_cnt != RST_CNT) begin
      rst_cnt <= rst_cnt + 16'd1;  // stops once reached
    end
  end

  // rst_n goes high on the RST_CNT-th edge after lock and stays there
  always_ff @(posedge clk_40M or negedge clk_40MHz_locked) begin
    if (!clk_40MHz_locked) begin
      rst_n <= 1'b0;
    end else if (rst_cnt == RST_CNT - 16'd1) begin
      rst_n <= 1'b1;
    end
  end

endmodule

// ==== source/conv_pkg.sv ====
`include "conv_config.svh"

package conv_pkg;

  // one memory word, one feature map row
  typedef logic [`CONV_LANES*8-1:0] mem_word_t;

  // word address on the memory port
  typedef logic [31:0] mem_addr_t;

  // int8 pixel or weight
  typedef logic signed [7:0] pixel_t;

  // 9 products of int8 x int8 stay below 2^18, so 20 bits is safe
  typedef logic signed [19:0] acc_t;

  // requantization right shift, low nibble of byte 9
  typedef logic [3:0] shift_t;

  // counts rows, responses and writes within a run (max 17)
  typedef logic [4:0] row_cnt_t;

  // controller FSM
  typedef enum logic [2:0] {
    IDLE,          // waiting for start
    LOAD_WEIGHTS,  // put the weight read in the request slot
    WAIT_WEIGHTS,  // weight word still outstanding
    STREAM,        // row reads and result writes
    FINISH         // done pulse
  } seq_state_t;

endpackage

// ==== source/conv_config.svh ====
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// reset release
////////////////////////////////////////////////////////////////////////////

`define CONV_RST_CNT      2000  // clk_40M cycles from lock to rst_n high

////////////////////////////////////////////////////////////////////////////
// feature map geometry
////////////////////////////////////////////////////////////////////////////

`define CONV_MAP_ROWS     16    // input rows
`define CONV_OUT_ROWS     14    // output rows, MAP_ROWS - 2
`define CONV_LANES        64    // bytes per memory word
`define CONV_OUT_LANES    62    // valid output bytes, LANES - 2
`define CONV_KSIZE        3     // kernel is KSIZE x KSIZE
`define CONV_SHIFT_BYTE   9     // byte of the weight word holding the shift

////////////////////////////////////////////////////////////////////////////
// memory map, in word addresses
////////////////////////////////////////////////////////////////////////////

`define CONV_WEIGHT_ADDR  0
`define CONV_IN_BASE      16
`define CONV_OUT_BASE     64

// rows past row 1 that may be read ahead of the result writes
`define CONV_MAX_INFLIGHT 2

`endif
